//--- hw/dcache_pkg.sv
// Shared cache geometry, access sizes, address views and FSM states; import where needed
package dcache_pkg;

  // ======================================================================
  // Geometry
  // ======================================================================
  localparam int ADDR_W     = 32;
  localparam int LINES      = 32;
  localparam int INDEX_W    = 5;
  localparam int WORD_SEL_W = 2;
  localparam int TAG_W      = ADDR_W - INDEX_W - WORD_SEL_W - 2;
  localparam int LINE_W     = 128;
  localparam int LINE_BE_W  = LINE_W / 8;

  // Access size on core and memory ports
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // ======================================================================
  // Address decode
  // ======================================================================
  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [INDEX_W-1:0]    index;
    logic [WORD_SEL_W-1:0] word_sel;
    logic [1:0]            byte_off;
  } dcache_addr_f_t;

  // Raw word for the bus, fields for the arrays
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    dcache_addr_f_t    f;
  } dcache_addr_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    CHK   = 3'd1,
    WHIT  = 3'd2,
    WMISS = 3'd3,
    RMISS = 3'd4
  } dcache_state_e;

endpackage

//--- hw/dcache_data_array.sv
// Line data storage, one cycle read latency, byte-granular writes from the cache controller
module dcache_data_array (
  input  logic                             clk,
  input  logic [dcache_pkg::INDEX_W-1:0]   index,
  input  logic                             rd,
  input  logic [dcache_pkg::LINE_BE_W-1:0] be,
  input  logic [dcache_pkg::LINE_W-1:0]    wdata,
  output logic [dcache_pkg::LINE_W-1:0]    rdata
);

  import dcache_pkg::*;

  // One entry per line, split into byte lanes
  logic [LINE_BE_W-1:0][7:0] mem [LINES];
  logic [LINE_BE_W-1:0][7:0] wbytes;

  assign wbytes = wdata;

  // Registered read port
  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= mem[index];
    end
  end

  // Per-byte write
  always_ff @(posedge clk) begin
    for (int b = 0; b < LINE_BE_W; b++) begin
      if (be[b]) begin
        mem[index][b] <= wbytes[b];
      end
    end
  end

endmodule

//--- hw/dcache_tag_array.sv
// Tag storage, one cycle read latency, written on line fill and write hit
module dcache_tag_array (
  input  logic                           clk,
  input  logic [dcache_pkg::INDEX_W-1:0] index,
  input  logic                           rd,
  input  logic                           we,
  input  logic [dcache_pkg::TAG_W-1:0]   wdata,
  output logic [dcache_pkg::TAG_W-1:0]   rdata
);

  import dcache_pkg::*;

  logic [TAG_W-1:0] mem [LINES];

  // Read output only moves when rd is set
  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= mem[index];
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wdata;
    end
  end

endmodule

//--- hw/dcache_ctrl.sv
// Data cache controller: hit/miss FSM, valid bits, line fill and write-through requests
module dcache_ctrl (
  input  logic                             clk,
  input  logic                             rstn,
  // Core side
  input  logic                             core_req,
  input  logic                             core_write,
  input  logic [dcache_pkg::ADDR_W-1:0]    core_addr,
  input  logic [dcache_pkg::ADDR_W-1:0]    core_wdata,
  input  dcache_pkg::size_e                core_size,
  output logic [dcache_pkg::ADDR_W-1:0]    core_rdata,
  output logic                             core_wait,
  // Memory side
  output logic                             mem_req,
  output logic                             mem_write,
  output logic [dcache_pkg::ADDR_W-1:0]    mem_addr,
  output logic [dcache_pkg::ADDR_W-1:0]    mem_wdata,
  output dcache_pkg::size_e                mem_size,
  input  logic [dcache_pkg::ADDR_W-1:0]    mem_rdata,
  input  logic                             mem_ack,
  // Array side
  output logic [dcache_pkg::INDEX_W-1:0]   index,
  output logic                             tag_rd,
  output logic                             data_rd,
  output logic                             tag_we,
  output logic [dcache_pkg::LINE_BE_W-1:0] data_be,
  output logic [dcache_pkg::TAG_W-1:0]     tag_wdata,
  input  logic [dcache_pkg::TAG_W-1:0]     tag_rdata,
  output logic [dcache_pkg::LINE_W-1:0]    line_wdata,
  input  logic [dcache_pkg::LINE_W-1:0]    line_rdata
);

  import dcache_pkg::*;

  dcache_state_e state, state_nxt;

  dcache_addr_t core_a;
  dcache_addr_t addr_q;
  dcache_addr_t fill_addr;

  logic [ADDR_W-1:0] wdata_q;
  size_e             size_q;
  logic              write_q;

  logic [LINES-1:0]  valid;
  logic [1:0]        beat_cnt;
  logic              req_done;
  logic              accept;
  logic              hit;
  logic              last_beat;
  logic              busy_mem;

  logic [LINE_W-1:0] line_q;
  logic [LINE_W-1:0] fill_line;
  logic [3:0]        word_be;
  logic [LINE_BE_W-1:0] line_be;

  assign core_a    = core_addr;
  assign accept    = (state == IDLE) && core_req;
  assign hit       = (tag_rdata == addr_q.f.tag);
  assign last_beat = (state == RMISS) && mem_ack && (beat_cnt == 2'd3);
  assign core_wait = (state != IDLE);

  // ======================================================================
  // Request capture
  // ======================================================================
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= core_a;
      wdata_q <= core_wdata;
      size_q  <= core_size;
      write_q <= core_write;
    end
  end

  // ======================================================================
  // State machine
  // ======================================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (core_req) begin
          // Invalid line skips the tag compare
          if (!valid[core_a.f.index]) begin
            state_nxt = core_write ? WMISS : RMISS;
          end else begin
            state_nxt = CHK;
          end
        end
      end
      CHK: begin
        if (write_q) begin
          state_nxt = hit ? WHIT : WMISS;
        end else begin
          state_nxt = hit ? IDLE : RMISS;
        end
      end
      WHIT, WMISS: begin
        if (mem_ack) begin
          state_nxt = IDLE;
        end
      end
      RMISS: begin
        if (last_beat) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  // Valid bits, set when a fill completes
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else if (last_beat) begin
      valid[addr_q.f.index] <= 1'b1;
    end
  end

  // Beat counter for the line fill
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_cnt <= 2'd0;
    end else if (state == IDLE) begin
      beat_cnt <= 2'd0;
    end else if (state == RMISS && mem_ack) begin
      beat_cnt <= beat_cnt + 2'd1;
    end
  end

  // Beats shift in from the top, word 0 ends at the bottom
  always_ff @(posedge clk) begin
    if (state == RMISS && mem_ack) begin
      line_q <= fill_line;
    end
  end

  assign fill_line = {mem_rdata, line_q[LINE_W-1:ADDR_W]};

  // ======================================================================
  // Array control
  // ======================================================================
  assign index     = (state == IDLE) ? core_a.f.index : addr_q.f.index;
  assign tag_rd    = accept;
  assign data_rd   = accept;
  assign tag_wdata = addr_q.f.tag;
  assign tag_we    = last_beat || (state == WHIT && mem_ack);

  // Lane enables within one word
  always_comb begin
    case (size_q)
      SIZE_BYTE: word_be = 4'b0001 << addr_q.f.byte_off;
      SIZE_HALF: word_be = addr_q.f.byte_off[1] ? 4'b1100 : 4'b0011;
      default:   word_be = 4'b1111;
    endcase
    line_be = LINE_BE_W'(word_be) << {addr_q.f.word_sel, 2'b00};
  end

  always_comb begin
    if (last_beat) begin
      data_be = '1;
    end else if (state == WHIT && mem_ack) begin
      data_be = line_be;
    end else begin
      data_be = '0;
    end
  end

  // Store data copied to every word, the enables pick one
  assign line_wdata = (state == WHIT) ? {4{wdata_q}} : fill_line;

  // Load result
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      core_rdata <= '0;
    end else if (state == CHK && !write_q && hit) begin
      core_rdata <= line_rdata[{addr_q.f.word_sel, 5'b0} +: ADDR_W];
    end else if (last_beat) begin
      core_rdata <= fill_line[{addr_q.f.word_sel, 5'b0} +: ADDR_W];
    end
  end

  // ======================================================================
  // Memory requests
  // ======================================================================
  assign busy_mem = (state == RMISS) || (state == WMISS) || (state == WHIT);

  // One request per access
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      req_done <= 1'b0;
    end else if (state == IDLE) begin
      req_done <= 1'b0;
    end else if (mem_req) begin
      req_done <= 1'b1;
    end
  end

  assign mem_req   = busy_mem && !req_done;
  assign mem_write = mem_req && (state != RMISS);

  always_comb begin
    fill_addr            = addr_q;
    fill_addr.f.word_sel = '0;
    fill_addr.f.byte_off = 2'b00;
    case (state)
      WHIT, WMISS: begin
        mem_addr  = addr_q.raw;
        mem_wdata = wdata_q;
        mem_size  = size_q;
      end
      RMISS: begin
        mem_addr  = fill_addr.raw;
        mem_wdata = '0;
        mem_size  = SIZE_WORD;
      end
      default: begin
        mem_addr  = '0;
        mem_wdata = '0;
        mem_size  = SIZE_WORD;
      end
    endcase
  end

endmodule

//--- hw/dcache_top.sv
// Data cache top level joining the controller with its data and tag arrays
module dcache_top (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          core_req,
  input  logic                          core_write,
  input  logic [dcache_pkg::ADDR_W-1:0] core_addr,
  input  logic [dcache_pkg::ADDR_W-1:0] core_wdata,
  input  dcache_pkg::size_e             core_size,
  output logic [dcache_pkg::ADDR_W-1:0] core_rdata,
  output logic                          core_wait,
  output logic                          mem_req,
  output logic                          mem_write,
  output logic [dcache_pkg::ADDR_W-1:0] mem_addr,
  output logic [dcache_pkg::ADDR_W-1:0] mem_wdata,
  output dcache_pkg::size_e             mem_size,
  input  logic [dcache_pkg::ADDR_W-1:0] mem_rdata,
  input  logic                          mem_ack
);

  import dcache_pkg::*;

  logic [INDEX_W-1:0]   index;
  logic                 tag_rd;
  logic                 data_rd;
  logic                 tag_we;
  logic [LINE_BE_W-1:0] data_be;
  logic [TAG_W-1:0]     tag_wdata;
  logic [TAG_W-1:0]     tag_rdata;
  logic [LINE_W-1:0]    line_wdata;
  logic [LINE_W-1:0]    line_rdata;

  dcache_ctrl i_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .core_req   (core_req),
    .core_write (core_write),
    .core_addr  (core_addr),
    .core_wdata (core_wdata),
    .core_size  (core_size),
    .core_rdata (core_rdata),
    .core_wait  (core_wait),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_size   (mem_size),
    .mem_rdata  (mem_rdata),
    .mem_ack    (mem_ack),
    .index      (index),
    .tag_rd     (tag_rd),
    .data_rd    (data_rd),
    .tag_we     (tag_we),
    .data_be    (data_be),
    .tag_wdata  (tag_wdata),
    .tag_rdata  (tag_rdata),
    .line_wdata (line_wdata),
    .line_rdata (line_rdata)
  );

  dcache_data_array i_data (
    .clk   (clk),
    .index (index),
    .rd    (data_rd),
    .be    (data_be),
    .wdata (line_wdata),
    .rdata (line_rdata)
  );

  dcache_tag_array i_tag (
    .clk   (clk),
    .index (index),
    .rd    (tag_rd),
    .we    (tag_we),
    .wdata (tag_wdata),
    .rdata (tag_rdata)
  );

endmodule

//--- tb/dcache_chk.sv
// Bus protocol assertions for the cache controller, attached to every dcache_ctrl by bind
module dcache_chk (
  input logic                          clk,
  input logic                          rstn,
  input dcache_pkg::dcache_state_e     state,
  input logic                          core_req,
  input logic                          mem_req,
  input logic                          mem_write,
  input logic [dcache_pkg::ADDR_W-1:0] mem_addr,
  input logic                          core_wait
);

  import dcache_pkg::*;

  int unsigned fail_cnt = 0;

  // Single-cycle request pulse
  a_req_pulse: assert property (@(posedge clk) disable iff (!rstn) mem_req |=> !mem_req)
    else begin
      $error("mem_req held longer than one cycle");
      fail_cnt++;
    end

  a_req_busy: assert property (@(posedge clk) disable iff (!rstn) !(mem_req && state == IDLE))
    else begin
      $error("mem_req raised in IDLE");
      fail_cnt++;
    end

  // Accepted request raises the wait in the next cycle
  a_accept_wait: assert property (@(posedge clk) disable iff (!rstn)
      state == IDLE && core_req |=> core_wait)
    else begin
      $error("core_wait not raised after an accepted request");
      fail_cnt++;
    end

  // Line fills start on a line boundary
  a_fill_align: assert property (@(posedge clk) disable iff (!rstn)
      mem_req && !mem_write |-> mem_addr[WORD_SEL_W+1:0] == '0)
    else begin
      $error("line fill address not line aligned");
      fail_cnt++;
    end

endmodule

bind dcache_ctrl dcache_chk i_chk (
  .clk       (clk),
  .rstn      (rstn),
  .state     (state),
  .core_req  (core_req),
  .mem_req   (mem_req),
  .mem_write (mem_write),
  .mem_addr  (mem_addr),
  .core_wait (core_wait)
);

//--- tb/tb_dcache.sv
// Testbench for the data cache with seeded random core traffic checked against a reference model
module tb_dcache;

  import dcache_pkg::*;

  localparam int CLK_HALF   = 2;
  localparam int RST_CYCLES = 4;
  localparam int N_RANDOM   = 400;
  localparam int N_DIRECTED = 15;
  localparam int OP_CYCLES  = 40;
  localparam int WATCHDOG   = ((N_RANDOM + N_DIRECTED) * OP_CYCLES + RST_CYCLES) * 2 * CLK_HALF;

  logic              clk;
  logic              rstn;
  logic              core_req;
  logic              core_write;
  logic [ADDR_W-1:0] core_addr;
  logic [ADDR_W-1:0] core_wdata;
  size_e             core_size;
  logic [ADDR_W-1:0] core_rdata;
  logic              core_wait;
  logic              mem_req;
  logic              mem_write;
  logic [ADDR_W-1:0] mem_addr;
  logic [ADDR_W-1:0] mem_wdata;
  size_e             mem_size;
  logic [ADDR_W-1:0] mem_rdata;
  logic              mem_ack;

  // Sparse backing memory keyed by word address
  logic [ADDR_W-1:0] mem_store [logic [ADDR_W-1:0]];

  // Memory transactions as seen on the bus
  logic              txn_write_q [$];
  logic [ADDR_W-1:0] txn_addr_q  [$];
  logic [ADDR_W-1:0] txn_wdata_q [$];
  size_e             txn_size_q  [$];

  // Reference cache state
  logic              ref_valid [LINES];
  logic [TAG_W-1:0]  ref_tag   [LINES];
  logic [ADDR_W-1:0] ref_line  [LINES][4];

  int unsigned test_errs;
  int unsigned total_errs;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned chk_errs;
  logic        aborted;

  dcache_top i_dut (
    .clk        (clk),
    .rstn       (rstn),
    .core_req   (core_req),
    .core_write (core_write),
    .core_addr  (core_addr),
    .core_wdata (core_wdata),
    .core_size  (core_size),
    .core_rdata (core_rdata),
    .core_wait  (core_wait),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_size   (mem_size),
    .mem_rdata  (mem_rdata),
    .mem_ack    (mem_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // ======================================================================
  // Helpers
  // ======================================================================
  function automatic logic [ADDR_W-1:0] fill_word(logic [ADDR_W-1:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h1357_9bdf;
  endfunction

  function automatic logic [ADDR_W-1:0] mem_word(logic [ADDR_W-1:0] a);
    logic [ADDR_W-1:0] wa;
    wa = {a[ADDR_W-1:2], 2'b00};
    if (mem_store.exists(wa)) begin
      return mem_store[wa];
    end
    return fill_word(wa);
  endfunction

  // Only the lanes named by size and offset change
  function automatic logic [ADDR_W-1:0] merge_store(logic [ADDR_W-1:0] old_w,
      logic [ADDR_W-1:0] new_w, size_e size, logic [1:0] off);
    logic [ADDR_W-1:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (size == SIZE_WORD || (size == SIZE_HALF && (b / 2) == off[1]) ||
          (size == SIZE_BYTE && b == off)) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [ADDR_W-1:0] make_addr(int tag, int idx, int ws, int off);
    dcache_addr_t a;
    a.f.tag      = TAG_W'(tag);
    a.f.index    = INDEX_W'(idx);
    a.f.word_sel = WORD_SEL_W'(ws);
    a.f.byte_off = 2'(off);
    return a.raw;
  endfunction

  task automatic compare_hex(input string name, input logic [ADDR_W-1:0] got,
      input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%08h exp 0x%08h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // ======================================================================
  // Memory model
  // ======================================================================
  initial begin : memory_model
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] wdata;
    size_e             size;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever begin
      @(negedge clk);
      if (rstn && mem_req) begin
        wr    = mem_write;
        addr  = mem_addr;
        wdata = mem_wdata;
        size  = mem_size;
        txn_write_q.push_back(wr);
        txn_addr_q.push_back(addr);
        txn_wdata_q.push_back(wdata);
        txn_size_q.push_back(size);
        for (int beat = 0; beat < (wr ? 1 : 4); beat++) begin
          @(negedge clk);
          mem_ack = 1'b0;
          repeat ($urandom_range(3)) @(negedge clk);
          mem_ack = 1'b1;
          if (wr) begin
            mem_store[{addr[ADDR_W-1:2], 2'b00}] = merge_store(mem_word(addr), wdata, size,
                                                               addr[1:0]);
          end else begin
            mem_rdata = mem_word(addr + 4 * beat);
          end
        end
        @(negedge clk);
        mem_ack = 1'b0;
      end
    end
  end

  // ======================================================================
  // One core access, checked against the reference model
  // ======================================================================
  task automatic run_access(input logic wr, input logic [ADDR_W-1:0] addr,
      input logic [ADDR_W-1:0] wdata, input size_e size);
    dcache_addr_t      a;
    dcache_addr_t      fa;
    logic              hit;
    logic [ADDR_W-1:0] exp_rdata;
    int                n_txn;
    int                exp_n;
    int                waits;
    if (aborted) begin
      return;
    end
    a.raw     = addr;
    hit       = ref_valid[a.f.index] && (ref_tag[a.f.index] == a.f.tag);
    n_txn     = txn_addr_q.size();
    exp_n     = (wr || !hit) ? 1 : 0;
    exp_rdata = hit ? ref_line[a.f.index][a.f.word_sel] : mem_word(addr);

    core_req   = 1'b1;
    core_write = wr;
    core_addr  = addr;
    core_wdata = wdata;
    core_size  = size;
    @(negedge clk);
    // Inputs matter only in the accept cycle
    core_req   = 1'b0;
    core_addr  = $urandom();
    core_wdata = $urandom();
    waits = 0;
    while (core_wait && waits < OP_CYCLES) begin
      waits++;
      @(negedge clk);
    end
    if (core_wait) begin
      $display("core_wait stuck high for %0d cycles on access to %08h", waits, addr);
      test_errs++;
      aborted = 1'b1;
      return;
    end

    if (txn_addr_q.size() != n_txn + exp_n) begin
      $display("saw %0d memory requests instead of %0d for %s at %08h",
               txn_addr_q.size() - n_txn, exp_n, wr ? "write" : "read", addr);
      test_errs++;
    end else if (exp_n == 1) begin
      compare_hex("mem_write", txn_write_q[n_txn], wr);
      compare_hex("mem_size", txn_size_q[n_txn], wr ? size : SIZE_WORD);
      if (wr) begin
        compare_hex("mem_addr", txn_addr_q[n_txn], addr);
        compare_hex("mem_wdata", txn_wdata_q[n_txn], wdata);
      end else begin
        compare_hex("mem_addr", txn_addr_q[n_txn], {addr[ADDR_W-1:4], 4'h0});
      end
    end

    if (!wr) begin
      compare_hex("core_rdata", core_rdata, exp_rdata);
      if (hit) begin
        compare_hex("core_wait cycles", waits, 1);
      end
    end

    // Fill on read miss, merge on write hit and nothing on write miss
    if (!wr && !hit) begin
      fa = a;
      fa.f.byte_off = 2'b00;
      for (int w = 0; w < 4; w++) begin
        fa.f.word_sel = WORD_SEL_W'(w);
        ref_line[a.f.index][w] = mem_word(fa.raw);
      end
      ref_valid[a.f.index] = 1'b1;
      ref_tag[a.f.index]   = a.f.tag;
    end else if (wr && hit) begin
      ref_line[a.f.index][a.f.word_sel] = merge_store(ref_line[a.f.index][a.f.word_sel],
                                                      wdata, size, a.f.byte_off);
    end
  endtask

  // ======================================================================
  // Tests
  // ======================================================================
  task automatic test_reset();
    int n;
    compare_hex("core_wait", core_wait, 1'b0);
    compare_hex("mem_req", mem_req, 1'b0);
    compare_hex("mem_write", mem_write, 1'b0);
    compare_hex("core_rdata", core_rdata, '0);
    n = txn_addr_q.size();
    run_access(1'b0, make_addr(5, 7, 1, 0), '0, SIZE_WORD);
    if (txn_addr_q.size() == n) begin
      $display("first read after reset did not reach memory");
      test_errs++;
    end
    finish_test("reset");
  endtask

  task automatic test_read_miss();
    run_access(1'b0, make_addr(6, 9, 2, 0), '0, SIZE_WORD);
    // Same index, other tag
    run_access(1'b0, make_addr(7, 9, 3, 0), '0, SIZE_WORD);
    finish_test("read_miss");
  endtask

  task automatic test_read_hit();
    run_access(1'b0, make_addr(7, 9, 0, 0), '0, SIZE_WORD);
    run_access(1'b0, make_addr(7, 9, 1, 0), '0, SIZE_WORD);
    finish_test("read_hit");
  endtask

  task automatic test_write_hit();
    run_access(1'b1, make_addr(7, 9, 2, 1), $urandom(), SIZE_BYTE);
    run_access(1'b1, make_addr(7, 9, 2, 2), $urandom(), SIZE_HALF);
    run_access(1'b1, make_addr(7, 9, 3, 0), $urandom(), SIZE_WORD);
    run_access(1'b0, make_addr(7, 9, 2, 0), '0, SIZE_WORD);
    run_access(1'b0, make_addr(7, 9, 3, 0), '0, SIZE_WORD);
    finish_test("write_hit");
  endtask

  task automatic test_write_miss();
    run_access(1'b1, make_addr(8, 10, 1, 0), $urandom(), SIZE_WORD);
    run_access(1'b1, make_addr(8, 10, 1, 3), $urandom(), SIZE_BYTE);
    run_access(1'b0, make_addr(8, 10, 1, 0), '0, SIZE_WORD);
    // Valid line holding another tag
    run_access(1'b1, make_addr(6, 9, 0, 2), $urandom(), SIZE_HALF);
    run_access(1'b0, make_addr(6, 9, 0, 0), '0, SIZE_WORD);
    finish_test("write_miss");
  endtask

  task automatic test_random();
    size_e size;
    int    off;
    for (int i = 0; i < N_RANDOM; i++) begin
      size = size_e'($urandom_range(2));
      case (size)
        SIZE_BYTE: off = $urandom_range(3);
        SIZE_HALF: off = 2 * $urandom_range(1);
        default:   off = 0;
      endcase
      run_access($urandom_range(2) == 0,
                 make_addr(32'h40 + $urandom_range(1), $urandom_range(3), $urandom_range(3), off),
                 $urandom(), size);
    end
    finish_test("random");
  endtask

  initial begin : watchdog
    #(WATCHDOG);
    $display("watchdog expired after %0d time units, the run did not finish", WATCHDOG);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    void'($urandom(32'h75c));
    rstn       = 1'b0;
    core_req   = 1'b0;
    core_write = 1'b0;
    core_addr  = '0;
    core_wdata = '0;
    core_size  = SIZE_WORD;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    for (int i = 0; i < LINES; i++) begin
      ref_valid[i] = 1'b0;
    end
    repeat (RST_CYCLES) @(negedge clk);
    rstn = 1'b1;

    test_reset();
    test_read_miss();
    test_read_hit();
    test_write_hit();
    test_write_miss();
    test_random();

    chk_errs = i_dut.i_ctrl.i_chk.fail_cnt;
    $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, total_errs, chk_errs);
    if (tests_failed == 0 && chk_errs == 0 && !aborted) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
hw/dcache_pkg.sv
hw/dcache_data_array.sv
hw/dcache_tag_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tb/dcache_chk.sv
tb/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - hw/dcache_pkg.sv
      - hw/dcache_data_array.sv
      - hw/dcache_tag_array.sv
      - hw/dcache_ctrl.sv
      - hw/dcache_top.sv
  - target: test
    files:
      - tb/dcache_chk.sv
      - tb/tb_dcache.sv
